// ==== modexp_array.f ====
+incdir+include
rtl/modexp_pkg.sv
rtl/modmult.sv
rtl/modexp_lane.sv
rtl/job_dispatch.sv
rtl/result_collect.sv
rtl/modexp_array.sv
verification/modexp_array_tb.sv

// ==== rtl/job_dispatch.sv ====
`timescale 1ns/1ns
module job_dispatch import modexp_pkg::*; #(
	parameter int LANES = 4,
	parameter int N     = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic [N-1:0]     m,
	input  logic [N-1:0]     e,
	input  logic [N-1:0]     n,
	input  logic [LANES-1:0] lane_idle,
	output logic [LANES-1:0] lane_start,
	output logic [N-1:0]     m_q,
	output logic [N-1:0]     e_q,
	output logic [N-1:0]     n_q,
	output logic             full
);
	logic [LANES-1:0] avail;
	logic [LANES-1:0] grant;
	lane_id_t         pick;
	logic             found;
	logic             accept;

	// lowest idle lane wins
	// a lane granted last cycle still shows idle, so mask it out
	always_comb
	begin
		avail = lane_idle & ~lane_start;
		pick = '0;
		found = 1'b0;
		for (int i = LANES - 1; i >= 0; i--)
		begin
			if (avail[i])
			begin
				pick = lane_id_t'(i);
				found = 1'b1;
			end
		end
		accept = start && !full && found;
		grant = accept ? (LANES'(1) << pick) : '0;
	end

	// start pulses and full level
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			lane_start <= '0;
			full <= 1'b0;
		end
		else
		begin
			lane_start <= grant;
			// full once the grant takes the last free lane
			full <= ((avail & ~grant) == '0);
		end
	end

	// shared operands, sampled by the lane on its start pulse
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			m_q <= m;
			e_q <= e;
			n_q <= n;
		end
	end

	// no queue here, a start while full is lost
	a_no_start_full: assert property (@(posedge clk) disable iff (rst) start |-> !full);

endmodule

// ==== rtl/modexp_array.sv ====
`timescale 1ns/1ns
module modexp_array import modexp_pkg::*; #(
	parameter int N     = 8,
	parameter int LANES = 4
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  logic [N-1:0] m,
	input  logic [N-1:0] e,
	input  logic [N-1:0] n,
	output logic         full,
	output logic         done,
	output logic [N-1:0] result,
	output lane_id_t     lane
);
	logic [LANES-1:0]        lane_start;
	logic [LANES-1:0]        lane_idle;
	logic [LANES-1:0]        lane_done;
	logic [LANES-1:0][N-1:0] lane_result;
	logic [N-1:0]            m_q;
	logic [N-1:0]            e_q;
	logic [N-1:0]            n_q;

	// lane index type caps the lane count
	if (LANES > MAX_LANES)
		$error("LANES above MAX_LANES");

	job_dispatch #(
		.LANES (LANES),
		.N     (N)
	) u_dispatch (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.m          (m),
		.e          (e),
		.n          (n),
		.lane_idle  (lane_idle),
		.lane_start (lane_start),
		.m_q        (m_q),
		.e_q        (e_q),
		.n_q        (n_q),
		.full       (full)
	);

	// identical lanes share the registered operands
	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		modexp_lane #(
			.N(N)
		) u_lane (
			.clk    (clk),
			.rst    (rst),
			.start  (lane_start[i]),
			.m      (m_q),
			.e      (e_q),
			.n      (n_q),
			.idle   (lane_idle[i]),
			.done   (lane_done[i]),
			.result (lane_result[i])
		);
	end

	result_collect #(
		.LANES (LANES),
		.N     (N)
	) u_collect (
		.clk         (clk),
		.rst         (rst),
		.lane_done   (lane_done),
		.lane_result (lane_result),
		.done        (done),
		.result      (result),
		.lane        (lane)
	);

endmodule

// ==== rtl/modexp_lane.sv ====
`timescale 1ns/1ns
module modexp_lane import modexp_pkg::*; #(
	parameter int N = 8
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  logic [N-1:0] m,
	input  logic [N-1:0] e,
	input  logic [N-1:0] n,
	output logic         idle,
	output logic         done,
	output logic [N-1:0] result
);
	localparam int SW = $clog2(N+1);

	lane_phase_e   phase;
	logic [SW-1:0] slot;
	logic          kick;
	logic [N-1:0]  m_r;
	logic [N-1:0]  e_r;
	logic [N-1:0]  n_r;
	logic [N-1:0]  r;
	logic [N-1:0]  r_next;
	logic          keep;
	logic          last;
	logic          mult_start;
	logic [N-1:0]  mx;
	logic [N-1:0]  my;
	logic [N-1:0]  mo;
	logic          mult_done;

	// square result always kept, multiply result only on a one bit
	assign keep = mult_done && ((phase == PH_SQUARE) || e_r[N-1]);
	assign r_next = keep ? mo : r;
	assign last = (phase == PH_MULT) && (slot == SW'(1));

	// next product issued in the same cycle the previous one lands
	assign mult_start = kick || (mult_done && !last);
	assign mx = r_next;
	// after a square comes the multiply by m
	assign my = (mult_done && (phase == PH_SQUARE)) ? m_r : r_next;

	// sequencer
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			phase <= PH_IDLE;
			slot <= '0;
			kick <= 1'b0;
			idle <= 1'b1;
			done <= 1'b0;
		end
		else
		begin
			kick <= 1'b0;
			done <= 1'b0;
			if (start)
			begin
				phase <= PH_SQUARE;
				slot <= SW'(N);
				kick <= 1'b1;
				idle <= 1'b0;
			end
			else if (mult_done)
			begin
				if (phase == PH_SQUARE)
					phase <= PH_MULT;
				else if (last)
				begin
					// all N bit slots done
					phase <= PH_IDLE;
					idle <= 1'b1;
					done <= 1'b1;
				end
				else
				begin
					phase <= PH_SQUARE;
					slot <= slot - 1'b1;
				end
			end
		end
	end

	// operands, exponent shifter and running value
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			m_r <= m;
			e_r <= e;
			n_r <= n;
			r <= N'(1);
		end
		else
		begin
			r <= r_next;
			// exponent bit consumed once its multiply lands
			if (mult_done && (phase == PH_MULT))
				e_r <= {e_r[N-2:0], 1'b0};
		end
	end

	assign result = r;

	modmult #(
		.N(N)
	) u_modmult (
		.clk       (clk),
		.rst       (rst),
		.start     (mult_start),
		.x         (mx),
		.y         (my),
		.n         (n_r),
		.o         (mo),
		.mult_done (mult_done)
	);

	// dispatcher must only pick a lane that reports idle
	a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> idle);

endmodule

// ==== rtl/modexp_pkg.sv ====
package modexp_pkg;

	// lane count ceiling
	// lane_id_t must be able to index every lane
	localparam int MAX_LANES = 8;

	// index of one exponentiation lane
	typedef logic [$clog2(MAX_LANES)-1:0] lane_id_t;

	// lane sequencer phases
	// square and multiply alternate once per exponent bit
	typedef enum logic [1:0]
	{
		PH_IDLE   = 2'd0,
		PH_SQUARE = 2'd1,
		PH_MULT   = 2'd2
	} lane_phase_e;

endpackage

// ==== rtl/modmult.sv ====
`timescale 1ns/1ns
module modmult #(
	parameter int N = 8
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  logic [N-1:0] x,
	input  logic [N-1:0] y,
	input  logic [N-1:0] n,
	output logic [N-1:0] o,
	output logic         mult_done
);
	localparam int CW = $clog2(N+1);

	logic [N-1:0]  xr;
	logic [N-1:0]  yr;
	logic [N-1:0]  nr;
	logic [N-1:0]  acc;
	logic [CW-1:0] cnt;
	logic          busy;
	logic [N:0]    dbl;
	logic [N:0]    dbl_red;
	logic [N:0]    sum;
	logic [N:0]    sum_red;

	// one interleaved step per cycle
	// double the accumulator, reduce, then add x and reduce again
	always_comb
	begin
		dbl = {acc, 1'b0};
		dbl_red = (dbl >= {1'b0, nr}) ? dbl - {1'b0, nr} : dbl;
		sum = dbl_red + {1'b0, xr};
		sum_red = (sum >= {1'b0, nr}) ? sum - {1'b0, nr} : sum;
	end

	// step counter and done flag
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			mult_done <= 1'b0;
		end
		else
		begin
			mult_done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				cnt <= CW'(N);
			end
			else if (busy)
			begin
				cnt <= cnt - 1'b1;
				// last multiplier bit consumed on this edge
				if (cnt == CW'(1))
				begin
					busy <= 1'b0;
					mult_done <= 1'b1;
				end
			end
		end
	end

	// operands and accumulator, y scanned msb first
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			xr <= x;
			yr <= y;
			nr <= n;
			acc <= '0;
		end
		else if (busy)
		begin
			acc <= yr[N-1] ? sum_red[N-1:0] : dbl_red[N-1:0];
			yr <= {yr[N-2:0], 1'b0};
		end
	end

	assign o = acc;

	// a zero modulus would never reduce
	a_mod_nonzero: assert property (@(posedge clk) disable iff (rst) start |-> (n != '0));

endmodule

// ==== rtl/result_collect.sv ====
`timescale 1ns/1ns
module result_collect import modexp_pkg::*; #(
	parameter int LANES = 4,
	parameter int N     = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [LANES-1:0]        lane_done,
	input  logic [LANES-1:0][N-1:0] lane_result,
	output logic                    done,
	output logic [N-1:0]            result,
	output lane_id_t                lane
);
	lane_id_t     sel;
	logic [N-1:0] res_sel;
	logic         hit;

	// one-hot to index, picking the matching result on the way
	always_comb
	begin
		sel = '0;
		res_sel = '0;
		for (int i = 0; i < LANES; i++)
		begin
			if (lane_done[i])
			begin
				sel = lane_id_t'(i);
				res_sel = lane_result[i];
			end
		end
		hit = |lane_done;
	end

	// result strobe
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			done <= 1'b0;
		else
			done <= hit;
	end

	// tag and value held until the next completion
	always_ff @(posedge clk)
	begin
		if (hit)
		begin
			result <= res_sel;
			lane <= sel;
		end
	end

	// fixed lane latency plus one start per cycle keeps completions apart
	a_done_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(lane_done));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the modexp_array testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module modexp_array_tb \
	-f modexp_array.f -o modexp_array_sim \
	&& ./obj_dir/modexp_array_sim > sim.log 2>&1 \
	|| { echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// error tallies, one per kind of check
int result_errors = 0;
int lane_errors = 0;
int flag_errors = 0;
int timeout_errors = 0;

// N-bit modular result
task automatic verify_result(input logic [N-1:0] got, input logic [N-1:0] want,
	input string what);
	if (got !== want)
	begin
		result_errors++;
		$display("[FAIL] %0t ns: %s: result %0d, expected %0d", $time, what, got, want);
	end
endtask

// lane tag of a result
task automatic compare_lane(input lane_id_t got, input lane_id_t want, input string what);
	if (got !== want)
	begin
		lane_errors++;
		$display("[FAIL] %0t ns: %s: lane %0d, expected %0d", $time, what, got, want);
	end
endtask

// single status bit
task automatic expect_flag(input logic got, input logic want, input string what);
	if (got !== want)
	begin
		flag_errors++;
		$display("[FAIL] %0t ns: %s: flag %b, expected %b", $time, what, got, want);
	end
endtask

`endif

// ==== verification/modexp_array_tb.sv ====
`timescale 1ns/1ns
module modexp_array_tb import modexp_pkg::*; ();
	localparam int N = 8;
	localparam int LANES = 4;
	localparam int NJOBS = 9;
	localparam int TIMEOUT = 1000;
	localparam int ROUNDS = 10;

	typedef struct packed {
		logic [N-1:0] m;
		logic [N-1:0] e;
		logic [N-1:0] n;
		logic [N-1:0] c;
	} job_row_t;

	logic         clk;
	logic         rst;
	logic         start;
	logic [N-1:0] m;
	logic [N-1:0] e;
	logic [N-1:0] n;
	logic         full;
	logic         done;
	logic [N-1:0] result;
	lane_id_t     lane;
	integer       seed = 32'hdeea;

	// m, e, n and the expected m^e mod n
	job_row_t jobs [NJOBS] = '{
		'{8'd3, 8'd5, 8'd7, 8'd5},
		'{8'd4, 8'd13, 8'd11, 8'd9},
		'{8'd5, 8'd0, 8'd13, 8'd1},
		'{8'd10, 8'd1, 8'd17, 8'd10},
		'{8'd2, 8'd255, 8'd255, 8'd128},
		'{8'd200, 8'd3, 8'd251, 8'd128},
		'{8'd0, 8'd7, 8'd9, 8'd0},
		'{8'd6, 8'd2, 8'd7, 8'd1},
		'{8'd1, 8'd200, 8'd2, 8'd1}
	};

	`include "tb_checks.svh"

	modexp_array #(
		.N     (N),
		.LANES (LANES)
	) dut (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.m      (m),
		.e      (e),
		.n      (n),
		.full   (full),
		.done   (done),
		.result (result),
		.lane   (lane)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// reference square-and-multiply from the exponent msb down
	// products kept at twice the operand width
	function automatic logic [N-1:0] modexp_model(input logic [N-1:0] b,
		input logic [N-1:0] ex, input logic [N-1:0] md);
		logic [2*N-1:0] acc;
		acc = 1;
		for (int i = N - 1; i >= 0; i--)
		begin
			acc = (acc * acc) % md;
			if (ex[i])
				acc = (acc * b) % md;
		end
		return acc[N-1:0];
	endfunction

	// operands and strobe change together on the rising edge
	task automatic drive_start(input logic [N-1:0] jm, input logic [N-1:0] je,
		input logic [N-1:0] jn);
		@(posedge clk);
		start <= 1'b1;
		m <= jm;
		e <= je;
		n <= jn;
	endtask

	task automatic drop_start();
		@(posedge clk);
		start <= 1'b0;
	endtask

	// returns on the falling edge where the result strobe is seen
	task automatic wait_done(output logic ok);
		int cycles;
		lane_phase_e ph;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < TIMEOUT)
		begin
			@(negedge clk);
			ok = (done === 1'b1);
			cycles++;
		end
		if (!ok)
		begin
			timeout_errors++;
			ph = dut.g_lane[0].u_lane.phase;
			$display("no result strobe within %0d cycles, lane 0 in phase %s",
				TIMEOUT, ph.name());
		end
	endtask

	// room for one more job
	task automatic wait_full_low(output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < TIMEOUT)
		begin
			@(negedge clk);
			ok = (full === 1'b0);
			cycles++;
		end
		if (!ok)
		begin
			timeout_errors++;
			$display("full stayed high for %0d cycles", TIMEOUT);
		end
	endtask

	initial
	begin
		logic         ok;
		logic [N-1:0] rm;
		logic [N-1:0] re;
		logic [N-1:0] rn;
		logic [N-1:0] want [MAX_LANES];
		int           burst;
		int           total;
		rst = 1'b1;
		start = 1'b0;
		m = '0;
		e = '0;
		n = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// table jobs one at a time
		// an idle array always hands out lane 0
		for (int i = 0; i < NJOBS; i++)
		begin
			drive_start(jobs[i].m, jobs[i].e, jobs[i].n);
			drop_start();
			wait_done(ok);
			if (ok)
			begin
				verify_result(result, jobs[i].c, "table job");
				compare_lane(lane, lane_id_t'(0), "table job");
				// all-ones exponent also against the model
				if (&jobs[i].e)
					verify_result(result, modexp_model(jobs[i].m, jobs[i].e, jobs[i].n),
						"all-ones exponent");
			end
		end

		// back-to-back starts fill every lane in order
		for (int k = 0; k < LANES; k++)
			drive_start(jobs[k].m, jobs[k].e, jobs[k].n);
		drop_start();
		@(negedge clk);
		expect_flag(full, 1'b1, "full after back-to-back starts");
		// equal latency keeps results in start order
		for (int k = 0; k < LANES; k++)
		begin
			wait_done(ok);
			if (ok)
			begin
				verify_result(result, jobs[k].c, "back-to-back job");
				compare_lane(lane, lane_id_t'(k), "back-to-back job");
				if (k == 0)
					expect_flag(full, 1'b0, "full after first done");
			end
		end

		// random bursts from an all-idle array
		for (int r = 0; r < ROUNDS; r++)
		begin
			burst = 1 + ($unsigned($random(seed)) % LANES);
			for (int k = 0; k < burst; k++)
			begin
				wait_full_low(ok);
				rn = N'(2 + ($unsigned($random(seed)) % 254));
				rm = N'($unsigned($random(seed)) % rn);
				re = N'($random(seed));
				// lowest idle lane takes the k-th job of a burst
				want[k] = modexp_model(rm, re, rn);
				drive_start(rm, re, rn);
				drop_start();
			end
			for (int k = 0; k < burst; k++)
			begin
				wait_done(ok);
				if (ok)
				begin
					compare_lane(lane, lane_id_t'(k), "random job");
					verify_result(result, want[k], "random job");
				end
			end
		end

		total = result_errors + lane_errors + flag_errors + timeout_errors;
		$display("errors: result %0d, lane %0d, flag %0d, timeout %0d",
			result_errors, lane_errors, flag_errors, timeout_errors);
		if (total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
